/* Makefile */
TOP = cam_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build cam_tb with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* capture/frame_capture.sv */
`default_nettype none

module frame_capture (
	input  wire logic                  S_CLK,
	input  wire logic                  RST_N,
	input  wire logic                  init_done,
	input  wire logic                  ov_vsync,
	input  wire cam_pkg::cam_byte_t    ov_data,
	input  wire fifo_pkg::fifo_level_t level,
	output logic                       ov_wrst,
	output logic                       ov_rrst,
	output logic                       ov_wen,
	output logic                       ov_rd,
	output cam_pkg::pixel_t            wdata,
	output logic                       wr,
	output logic                       frame_done
);

	cam_pkg::cap_state_t state;
	cam_pkg::rst_cnt_t   rst_cnt;
	logic                vs_meta;
	logic                vs_sync;
	logic                vs_prev;
	logic                vs_rise;
	logic                rd_d;
	logic                req_odd;
	cam_pkg::pixel_cnt_t req_pix;
	logic                byte_phase;
	cam_pkg::cam_byte_t  hi_byte;
	cam_pkg::pixel_cnt_t pix_cnt;
	logic                rst_last;
	logic                room;
	logic                req_left;
	logic                pix_done;
	logic                pix_last;

	assign vs_rise = vs_sync && !vs_prev;
	assign rst_last = rst_cnt == cam_pkg::rst_cnt_t'(cam_pkg::PTR_RST_CYCLES - 1);
	assign room = level < fifo_pkg::fifo_level_t'(fifo_pkg::FIFO_AFULL);
	// req_pix counts byte pairs already asked for, so the frame is never over-read
	assign req_left = req_pix != cam_pkg::pixel_cnt_t'(cam_pkg::FRAME_PIXELS);
	// the second byte of a pair is on ov_data this cycle
	assign pix_done = rd_d && byte_phase;
	assign pix_last = pix_cnt == cam_pkg::pixel_cnt_t'(cam_pkg::FRAME_PIXELS - 1);

	// read strobe follows the fill level in the same cycle so it never overshoots AFULL
	// at most one byte is in flight when it drops
	assign ov_rd = (state == cam_pkg::READ) && room && req_left;

	// vsync comes from the sensor clock domain
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			vs_meta <= 1'b0;
			vs_sync <= 1'b0;
			vs_prev <= 1'b0;
		end else begin
			vs_meta <= ov_vsync;
			vs_sync <= vs_meta;
			vs_prev <= vs_sync;
		end
	end

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= cam_pkg::INIT;
			rst_cnt <= '0;
			ov_wrst <= 1'b1;
			ov_rrst <= 1'b1;
			ov_wen <= 1'b0;
		end else begin
			case (state)
				cam_pkg::INIT: begin
					if (init_done) state <= cam_pkg::IDLE;
				end
				// a frame is only written from its start so wait for the next vsync
				cam_pkg::IDLE: begin
					if (vs_rise) begin
						ov_wrst <= 1'b0;
						rst_cnt <= '0;
						state <= cam_pkg::WRST;
					end
				end
				cam_pkg::WRST: begin
					rst_cnt <= rst_cnt + 1'b1;
					if (rst_last) begin
						ov_wrst <= 1'b1;
						ov_wen <= 1'b1;
						state <= cam_pkg::CAPT;
					end
				end
				// the sensor fills its FIFO until the following vsync ends the frame
				cam_pkg::CAPT: begin
					if (vs_rise) begin
						ov_wen <= 1'b0;
						ov_rrst <= 1'b0;
						rst_cnt <= '0;
						state <= cam_pkg::RRST;
					end
				end
				cam_pkg::RRST: begin
					rst_cnt <= rst_cnt + 1'b1;
					if (rst_last) begin
						ov_rrst <= 1'b1;
						state <= cam_pkg::READ;
					end
				end
				cam_pkg::READ: begin
					if (pix_done && pix_last) state <= cam_pkg::IDLE;
				end
				default: state <= cam_pkg::INIT;
			endcase
		end
	end

	// pairing follows the bytes as they arrive, not as they were requested
	// a pause between the two reads of a pair therefore cannot shift the alignment
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			rd_d <= 1'b0;
			req_odd <= 1'b0;
			req_pix <= '0;
			byte_phase <= 1'b0;
			pix_cnt <= '0;
			wr <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			rd_d <= ov_rd;
			wr <= pix_done;
			frame_done <= pix_done && pix_last;
			if (state == cam_pkg::RRST) begin
				req_odd <= 1'b0;
				req_pix <= '0;
				byte_phase <= 1'b0;
				pix_cnt <= '0;
			end else begin
				if (ov_rd) begin
					req_odd <= !req_odd;
					if (req_odd) req_pix <= req_pix + 1'b1;
				end
				if (rd_d) byte_phase <= !byte_phase;
				if (pix_done) pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge S_CLK) begin
		if (rd_d && !byte_phase) hi_byte <= ov_data;
		if (pix_done) wdata <= {hi_byte, ov_data};
	end

endmodule

`default_nettype wire

/* common/cam_pkg.sv */
`default_nettype none

package cam_pkg;

	// one byte as it appears on the camera data bus
	typedef logic [7:0] cam_byte_t;
	// two camera bytes packed into one pixel with the first byte in the upper half
	typedef logic [15:0] pixel_t;
	// wide enough for every pixel of a QVGA frame
	typedef logic [17:0] pixel_cnt_t;

	localparam int FRAME_W = 320;
	localparam int FRAME_H = 240;
	localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

	// a single SCCB register write as it goes out on the wire
	typedef struct packed {
		cam_byte_t dev_id;
		cam_byte_t reg_addr;
		cam_byte_t reg_val;
	} sccb_write_t;

	// write address of the OV7670 on the SCCB bus
	localparam cam_byte_t SCCB_ID = 8'h42;
	localparam int INIT_LEN = 8;
	typedef logic [$clog2(INIT_LEN)-1:0] init_idx_t;

	// soft reset first, then QVGA RGB565 output with the scaler and PCLK divider set up
	localparam sccb_write_t INIT_TABLE [INIT_LEN] = '{
		'{SCCB_ID, 8'h12, 8'h80},
		'{SCCB_ID, 8'h12, 8'h14},
		'{SCCB_ID, 8'h40, 8'hd0},
		'{SCCB_ID, 8'h11, 8'h01},
		'{SCCB_ID, 8'h0c, 8'h04},
		'{SCCB_ID, 8'h3e, 8'h19},
		'{SCCB_ID, 8'h70, 8'h3a},
		'{SCCB_ID, 8'h71, 8'h35}
	};

	// half an scl period in S_CLK cycles
	localparam int SCCB_HALF = 4;
	typedef logic [$clog2(SCCB_HALF)-1:0] sccb_phase_t;
	// three bytes each followed by the don't-care ninth bit
	localparam int SCCB_BITS = 27;
	typedef logic [4:0] sccb_bit_t;

	localparam int PTR_RST_CYCLES = 4;
	typedef logic [$clog2(PTR_RST_CYCLES)-1:0] rst_cnt_t;

	typedef enum logic [2:0] {INIT, IDLE, WRST, CAPT, RRST, READ} cap_state_t;

endpackage

`default_nettype wire

/* common/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

	// depth of the local pixel buffer between the camera and the consumer
	localparam int FIFO_DEPTH = 512;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	// address into the buffer memory
	typedef logic [FIFO_AW-1:0] fifo_ptr_t;
	// one bit wider than the pointer so that a full buffer can be told from an empty one
	typedef logic [FIFO_AW:0] fifo_level_t;

	// camera reads pause at or above this level
	// the gap to FIFO_DEPTH absorbs the pixel still in flight
	localparam int FIFO_AFULL = 500;

endpackage

`default_nettype wire

/* dv/cam_properties.sv */
`default_nettype none

module cam_properties (
	input wire logic                  S_CLK,
	input wire logic                  RST_N,
	input wire logic                  ov_wrst,
	input wire logic                  ov_rrst,
	input wire logic                  ov_wen,
	input wire logic                  ov_rd,
	input wire fifo_pkg::fifo_level_t level
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_cnt = 0;

	// the camera FIFO is either being filled by the sensor or read back, never both
	wen_rd_apart: assert property (@(posedge S_CLK) disable iff (!RST_N) !(ov_wen && ov_rd))
		else begin
			$error("ov_wen and ov_rd are high in the same cycle");
			fail_cnt++;
		end

	// only one pointer of the camera FIFO is reset at a time
	ptr_rst_apart: assert property (@(posedge S_CLK) disable iff (!RST_N) ov_wrst || ov_rrst)
		else begin
			$error("ov_wrst and ov_rrst are low in the same cycle");
			fail_cnt++;
		end

	// the almost-full margin takes every pixel still in flight so no push is ever dropped
	level_below_full: assert property (@(posedge S_CLK) disable iff (!RST_N)
		level < fifo_pkg::fifo_level_t'(fifo_pkg::FIFO_DEPTH))
		else begin
			$error("the pixel FIFO filled up completely");
			fail_cnt++;
		end

endmodule

`default_nettype wire

/* dv/cam_tb.sv */
`default_nettype none

module cam_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// selectors for the control outputs that the wait loops poll
	localparam int P_INIT = 0;
	localparam int P_WRST = 1;
	localparam int P_WEN = 2;
	localparam int P_RRST = 3;
	// cycles without a new pixel before the readout counts as stuck
	localparam int PIX_TIMEOUT = 5000;

	logic                 S_CLK;
	logic                 RST_N;
	logic                 ov_vsync;
	cam_pkg::cam_byte_t   ov_data = '0;
	logic                 pix_rd;
	logic                 scl;
	logic                 sda;
	logic                 ov_wrst;
	logic                 ov_rrst;
	logic                 ov_wen;
	logic                 ov_rd;
	cam_pkg::pixel_t      pix_data;
	logic                 pix_valid;
	logic                 frame_done;
	logic                 init_done;

	integer seed = 32'hac49ac04;
	int     offset = 0;
	int     cam_ptr = 0;
	int     errors = 0;
	int     timeouts = 0;
	bit     aborted = 1'b0;

	// SCCB decoder state
	cam_pkg::sccb_write_t          writes[$];
	logic [cam_pkg::SCCB_BITS-1:0] sccb_shift = '0;
	int                            sccb_bits = 0;
	bit                            in_write = 1'b0;
	int                            stop_cnt = 0;

	cam_top dut0 (.*);

	bind frame_capture cam_properties u_props (
		.S_CLK(S_CLK), .RST_N(RST_N), .ov_wrst(ov_wrst), .ov_rrst(ov_rrst),
		.ov_wen(ov_wen), .ov_rd(ov_rd), .level(level)
	);

	initial begin
		S_CLK = 1'b0;
		forever #4 S_CLK = ~S_CLK;
	end

	// byte stored at camera FIFO address p for the current frame
	function automatic cam_pkg::cam_byte_t cam_byte(input int p);
		return cam_pkg::cam_byte_t'(p * 7 + offset);
	endfunction

	// pixel n is the byte pair at 2n and 2n+1, first byte in the upper half
	function automatic cam_pkg::pixel_t expected_pixel(input int n);
		return {cam_byte(2 * n), cam_byte(2 * n + 1)};
	endfunction

	// camera FIFO model, each read strobe gets its byte on the following cycle
	always @(posedge S_CLK) begin
		if (ov_rrst === 1'b0) begin
			cam_ptr <= 0;
		end else if (ov_rd === 1'b1) begin
			ov_data <= cam_byte(cam_ptr);
			cam_ptr <= cam_ptr + 1;
		end
	end

	// start condition is sda falling while scl is high
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			in_write = 1'b1;
			sccb_bits = 0;
		end
	end

	// stop condition is sda rising while scl is high
	always @(posedge sda) begin
		if (scl === 1'b1 && in_write) begin
			in_write = 1'b0;
			stop_cnt++;
		end
	end

	// the scl pulse inside the stop condition is past the 27 bits and is ignored
	always @(posedge scl) begin
		if (in_write && sccb_bits < cam_pkg::SCCB_BITS) begin
			sccb_shift = {sccb_shift[cam_pkg::SCCB_BITS-2:0], sda};
			sccb_bits++;
			if (sccb_bits == cam_pkg::SCCB_BITS) begin
				// drop the ninth bit after each byte
				writes.push_back(cam_pkg::sccb_write_t'({sccb_shift[26:19],
					sccb_shift[17:10], sccb_shift[8:1]}));
			end
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_pixel(input string name, input cam_pkg::pixel_t got,
		input cam_pkg::pixel_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%04h expected 0x%04h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_write(input string name, input cam_pkg::sccb_write_t got,
		input cam_pkg::sccb_write_t exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%06h expected 0x%06h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timed out while waiting for %s", what);
		timeouts++;
		aborted = 1'b1;
	endtask

	function automatic logic value_of(input int sel);
		case (sel)
			P_INIT: return init_done;
			P_WRST: return ov_wrst;
			P_WEN: return ov_wen;
			P_RRST: return ov_rrst;
			default: return 1'bx;
		endcase
	endfunction

	// polls on falling edges, where every registered output is settled
	task automatic wait_level(input int sel, input logic val, input int limit,
		input string what);
		int n;
		n = 0;
		while (!aborted && value_of(sel) !== val) begin
			if (n == limit) begin
				note_timeout(what);
			end else begin
				@(negedge S_CLK);
				n++;
			end
		end
	endtask

	// length of a low pulse in whole clock cycles
	task automatic measure_low(input int sel, input string name);
		int n;
		wait_level(sel, 1'b0, 64, {name, " to go low"});
		n = 0;
		while (!aborted && value_of(sel) === 1'b0) begin
			if (n == 64) begin
				note_timeout({name, " to return high"});
			end else begin
				@(negedge S_CLK);
				n++;
			end
		end
		if (!aborted) check_count({name, " low cycles"}, n, cam_pkg::PTR_RST_CYCLES);
	endtask

	// vsync pulse on the sensor side, two clocks wide
	task automatic pulse_vsync();
		@(posedge S_CLK);
		ov_vsync <= 1'b1;
		repeat (2) @(posedge S_CLK);
		ov_vsync <= 1'b0;
		@(negedge S_CLK);
	endtask

	task automatic reset_state();
		@(negedge S_CLK);
		check_bit("ov_wrst", ov_wrst, 1'b1);
		check_bit("ov_rrst", ov_rrst, 1'b1);
		check_bit("ov_wen", ov_wen, 1'b0);
		check_bit("ov_rd", ov_rd, 1'b0);
		check_bit("pix_valid", pix_valid, 1'b0);
		check_bit("frame_done", frame_done, 1'b0);
		check_bit("init_done", init_done, 1'b0);
		check_bit("scl", scl, 1'b1);
		check_bit("sda", sda, 1'b1);
	endtask

	task automatic sensor_setup();
		wait_level(P_INIT, 1'b1, 10000, "init_done");
		// every stop condition is already on the bus when init_done is first seen
		check_count("SCCB stop conditions", stop_cnt, cam_pkg::INIT_LEN);
		check_count("SCCB writes", writes.size(), cam_pkg::INIT_LEN);
		foreach (writes[i]) begin
			if (i < cam_pkg::INIT_LEN) begin
				check_write($sformatf("sccb write %0d", i), writes[i], cam_pkg::INIT_TABLE[i]);
			end
		end
	endtask

	// collects one frame from the pixel FIFO, optionally with a stalling consumer
	task automatic drain_frame(input bit throttle);
		int n;
		int idle;
		int stretch;
		int pulses;
		bit saw_afull;
		n = 0;
		idle = 0;
		stretch = 0;
		pulses = 0;
		saw_afull = 1'b0;
		while (!aborted && n < cam_pkg::FRAME_PIXELS) begin
			@(posedge S_CLK);
			if (!throttle) begin
				pix_rd <= 1'b1;
			end else if (stretch > 0) begin
				stretch--;
			end else if (pix_rd) begin
				// long enough for the FIFO to climb to its almost-full level
				pix_rd <= 1'b0;
				stretch = 600 + int'($unsigned($random(seed)) % 900);
			end else begin
				pix_rd <= 1'b1;
				stretch = 100 + int'($unsigned($random(seed)) % 400);
			end
			@(negedge S_CLK);
			if (frame_done) pulses++;
			// camera reads must pause while the pixel FIFO is almost full
			if (dut0.level >= fifo_pkg::fifo_level_t'(fifo_pkg::FIFO_AFULL)) begin
				saw_afull = 1'b1;
				check_bit("ov_rd", ov_rd, 1'b0);
			end
			if (pix_valid) begin
				check_pixel($sformatf("pix_data[%0d]", n), pix_data, expected_pixel(n));
				n++;
				idle = 0;
			end else if (idle == PIX_TIMEOUT) begin
				note_timeout("the next pixel");
			end else begin
				idle++;
			end
		end
		// the consumer keeps reading, so a surplus pixel would show up here
		@(posedge S_CLK);
		pix_rd <= 1'b1;
		repeat (8) begin
			@(negedge S_CLK);
			if (frame_done) pulses++;
			if (pix_valid) begin
				$display("a pixel appeared after the end of the frame");
				errors++;
			end
		end
		check_count("frame_done pulses", pulses, 1);
		if (throttle && !saw_afull) begin
			$display("the pixel FIFO never reached its almost-full level");
			errors++;
		end
	endtask

	// one full frame: write pointer reset, capture, read pointer reset, readout
	task automatic run_capture(input bit throttle);
		offset = $random(seed);
		pulse_vsync();
		measure_low(P_WRST, "ov_wrst");
		check_bit("ov_wen", ov_wen, 1'b1);
		// the sensor writes its frame while ov_wen is high
		repeat (40) @(negedge S_CLK);
		pulse_vsync();
		wait_level(P_WEN, 1'b0, 64, "ov_wen to fall");
		check_bit("ov_rrst", ov_rrst, 1'b0);
		measure_low(P_RRST, "ov_rrst");
		drain_frame(throttle);
	endtask

	initial begin
		RST_N = 1'b0;
		ov_vsync = 1'b0;
		pix_rd = 1'b0;
		repeat (5) @(posedge S_CLK);
		RST_N <= 1'b1;
		reset_state();
		sensor_setup();
		@(posedge S_CLK);
		pix_rd <= 1'b1;
		// consumer always ready, then a second frame with a fresh offset
		run_capture(1'b0);
		run_capture(1'b0);
		run_capture(1'b1);
		$display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
			errors, timeouts, dut0.u_cap.u_props.fail_cnt);
		if (errors == 0 && timeouts == 0 && dut0.u_cap.u_props.fail_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sensor_init/sccb_writer.sv */
`default_nettype none

module sccb_writer (
	input  wire logic                 S_CLK,
	input  wire logic                 RST_N,
	input  wire cam_pkg::sccb_write_t cmd,
	input  wire logic                 start,
	output logic                      busy,
	output logic                      scl,
	output logic                      sda
);

	typedef enum logic [2:0] {W_IDLE, W_START, W_DATA, W_STOP, W_FREE} wr_state_t;

	wr_state_t                       state;
	cam_pkg::sccb_phase_t            phase;
	cam_pkg::sccb_bit_t              bit_cnt;
	logic [cam_pkg::SCCB_BITS-1:0]   shift;
	logic                            tick;
	logic                            accept;

	// tick marks the last cycle of each half scl period
	assign tick = phase == cam_pkg::sccb_phase_t'(cam_pkg::SCCB_HALF - 1);
	// a new write is only taken while the bus is idle
	assign accept = (state == W_IDLE) && start;

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= '0;
		end else if (state == W_IDLE || tick) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// each byte is followed by a ninth bit which is left high for the sensor to drive
	always_ff @(posedge S_CLK) begin
		if (accept) begin
			shift <= {cmd.dev_id, 1'b1, cmd.reg_addr, 1'b1, cmd.reg_val, 1'b1};
		end else if (state == W_DATA && tick && scl) begin
			shift <= shift << 1;
		end
	end

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= W_IDLE;
			bit_cnt <= '0;
			busy <= 1'b0;
			scl <= 1'b1;
			sda <= 1'b1;
		end else begin
			case (state)
				W_IDLE: begin
					if (accept) begin
						busy <= 1'b1;
						state <= W_START;
					end
				end
				// start condition
				// sda drops halfway through a full period of scl high
				W_START: begin
					if (tick) begin
						if (sda) begin
							sda <= 1'b0;
						end else begin
							scl <= 1'b0;
							bit_cnt <= '0;
							state <= W_DATA;
						end
					end
				end
				// sda moves one cycle into the low half and holds through the high half
				W_DATA: begin
					if (!scl && phase == '0) begin
						sda <= shift[cam_pkg::SCCB_BITS-1];
					end
					if (tick) begin
						if (!scl) begin
							scl <= 1'b1;
						end else begin
							scl <= 1'b0;
							if (bit_cnt == cam_pkg::sccb_bit_t'(cam_pkg::SCCB_BITS - 1)) begin
								state <= W_STOP;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
					end
				end
				// stop condition
				// sda goes low under scl low and rises once scl is high
				W_STOP: begin
					if (!scl && phase == '0) begin
						sda <= 1'b0;
					end
					if (tick) begin
						if (!scl) begin
							scl <= 1'b1;
						end else begin
							sda <= 1'b1;
							state <= W_FREE;
						end
					end
				end
				// bus stays released for half a period before the next start
				W_FREE: begin
					if (tick) begin
						busy <= 1'b0;
						state <= W_IDLE;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* sensor_init/sensor_config.sv */
`default_nettype none

module sensor_config (
	input  wire logic            S_CLK,
	input  wire logic            RST_N,
	input  wire logic            busy,
	output cam_pkg::sccb_write_t cmd,
	output logic                 start,
	output logic                 init_done
);

	typedef enum logic [1:0] {CFG_SEND, CFG_ARM, CFG_WAIT, CFG_DONE} cfg_state_t;

	cfg_state_t         state;
	cam_pkg::init_idx_t idx;

	// the writer takes its own copy of cmd on start so the entry can follow the index
	assign cmd = cam_pkg::INIT_TABLE[idx];

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= CFG_SEND;
			idx <= '0;
			start <= 1'b0;
			init_done <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				CFG_SEND: begin
					start <= 1'b1;
					state <= CFG_ARM;
				end
				// busy only goes high the cycle after the writer has seen start
				CFG_ARM: state <= CFG_WAIT;
				CFG_WAIT: begin
					if (!busy) begin
						if (idx == cam_pkg::init_idx_t'(cam_pkg::INIT_LEN - 1)) begin
							// last stop condition is out so the sensor is configured
							init_done <= 1'b1;
							state <= CFG_DONE;
						end else begin
							idx <= idx + 1'b1;
							state <= CFG_SEND;
						end
					end
				end
				default: state <= CFG_DONE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/cam_top.sv */
`default_nettype none

module cam_top (
	input  wire logic               S_CLK,
	input  wire logic               RST_N,
	output logic                    scl,
	output logic                    sda,
	input  wire logic               ov_vsync,
	input  wire cam_pkg::cam_byte_t ov_data,
	output logic                    ov_wrst,
	output logic                    ov_rrst,
	output logic                    ov_wen,
	output logic                    ov_rd,
	input  wire logic               pix_rd,
	output cam_pkg::pixel_t         pix_data,
	output logic                    pix_valid,
	output logic                    frame_done,
	output logic                    init_done
);

	cam_pkg::sccb_write_t  cmd;
	logic                  start;
	logic                  busy;
	cam_pkg::pixel_t       wdata;
	logic                  wr;
	fifo_pkg::fifo_level_t level;

	// register table walker and the serial writer it feeds
	sensor_config u_cfg (
		.S_CLK(S_CLK), .RST_N(RST_N), .busy(busy),
		.cmd(cmd), .start(start), .init_done(init_done)
	);

	sccb_writer u_sccb (
		.S_CLK(S_CLK), .RST_N(RST_N), .cmd(cmd), .start(start),
		.busy(busy), .scl(scl), .sda(sda)
	);

	// capture holds off until configuration has finished
	frame_capture u_cap (
		.S_CLK(S_CLK), .RST_N(RST_N), .init_done(init_done),
		.ov_vsync(ov_vsync), .ov_data(ov_data), .level(level),
		.ov_wrst(ov_wrst), .ov_rrst(ov_rrst), .ov_wen(ov_wen), .ov_rd(ov_rd),
		.wdata(wdata), .wr(wr), .frame_done(frame_done)
	);

	pixel_fifo u_fifo (
		.S_CLK(S_CLK), .RST_N(RST_N), .wdata(wdata), .wr(wr), .rd(pix_rd),
		.rdata(pix_data), .rvalid(pix_valid), .level(level)
	);

endmodule

`default_nettype wire

/* src/pixel_fifo.sv */
`default_nettype none

module pixel_fifo (
	input  wire logic            S_CLK,
	input  wire logic            RST_N,
	input  wire cam_pkg::pixel_t wdata,
	input  wire logic            wr,
	input  wire logic            rd,
	output cam_pkg::pixel_t      rdata,
	output logic                 rvalid,
	output fifo_pkg::fifo_level_t level
);

	cam_pkg::pixel_t     mem [fifo_pkg::FIFO_DEPTH];
	fifo_pkg::fifo_ptr_t wr_ptr;
	fifo_pkg::fifo_ptr_t rd_ptr;
	logic                full;
	logic                empty;
	logic                do_wr;
	logic                do_rd;

	assign full = level == fifo_pkg::fifo_level_t'(fifo_pkg::FIFO_DEPTH);
	assign empty = level == '0;
	// a push into a full buffer is lost
	// the capture side stops reading well before that point
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	always_ff @(posedge S_CLK) begin
		if (do_wr) mem[wr_ptr] <= wdata;
	end

	// the head word is registered so rdata lines up with rvalid
	always_ff @(posedge S_CLK) begin
		if (do_rd) rdata <= mem[rd_ptr];
	end

	// pointers wrap on their own since the depth is a power of two
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			rvalid <= 1'b0;
		end else begin
			rvalid <= do_rd;
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

endmodule

`default_nettype wire

/* tb.f */
common/cam_pkg.sv
common/fifo_pkg.sv
sensor_init/sensor_config.sv
sensor_init/sccb_writer.sv
capture/frame_capture.sv
src/pixel_fifo.sv
src/cam_top.sv
dv/cam_properties.sv
dv/cam_tb.sv
